/* rtl/reg_pkg.sv */
package reg_pkg;

	// Physical register file geometry
	localparam int TAG_BITS  = 6;                   // Width of a physical tag
	localparam int ARCH_REGS = 32;                  // Architectural registers
	localparam int PHYS_REGS = 64;                  // Total physical registers
	localparam int FREE_REGS = PHYS_REGS - ARCH_REGS; // Tags not held by the map at reset

	// Architectural index width
	localparam int ARCH_BITS = 5;

	// Physical tag, bit 5 set for tags that start life on the free list
	typedef logic [TAG_BITS-1:0] phys_tag_t;

	// Architectural destination register index
	typedef logic [ARCH_BITS-1:0] arch_reg_t;

endpackage

/* rtl/rob_pkg.sv */
package rob_pkg;

	import reg_pkg::*;

	// Eight rows, one always left open so full and empty differ
	localparam int ROB_SIZE     = 8;
	localparam int ROB_IDX_BITS = 3;

	// Row pointer, wraps naturally at ROB_SIZE
	typedef logic [ROB_IDX_BITS-1:0] rob_idx_t;

	// One in-flight instruction
	typedef struct packed {
		logic      busy;  // Row holds a live instruction
		logic      ready; // Result tag seen on the CDB
		phys_tag_t t_new; // Tag allocated at dispatch
		phys_tag_t t_old; // Previous mapping, freed at retire
		logic      halt;  // Halt marker carried to retire
	} rob_row_t;

endpackage

/* rtl/rob_tag_cam.sv */
`timescale 1ns/1ps

module rob_tag_cam
	import reg_pkg::*;
	import rob_pkg::*;
(
	input  rob_row_t [ROB_SIZE-1:0] rob_table, // Registered ROB rows
	input  logic                    cdb_valid, // Broadcast strobe
	input  phys_tag_t               cdb_tag,   // Completed tag
	output logic [ROB_SIZE-1:0]     hit        // One bit per matching row
);

	// Parallel compare of the broadcast tag against every row
	always_comb begin
		hit = '0;
		for (int i = 0; i < ROB_SIZE; i++) begin
			// Idle rows may hold an old t_new, so busy must qualify the match
			hit[i] = cdb_valid && rob_table[i].busy && (rob_table[i].t_new == cdb_tag);
		end
	end

endmodule

/* rtl/rob_core.sv */
`timescale 1ns/1ps

module rob_core
	import reg_pkg::*;
	import rob_pkg::*;
(
	input  logic      clock,
	input  logic      rst_n,
	input  logic      flush,            // Whole-buffer clear
	input  logic      dispatch_en,      // Instruction offered this cycle
	input  logic      dispatch_halt,    // Halt flag of the offered instruction
	input  phys_tag_t t_new,            // From free list head
	input  phys_tag_t t_old,            // From map table read
	input  logic      free_empty,       // No tag left to allocate
	input  logic      cdb_valid,
	input  phys_tag_t cdb_tag,
	output logic      dispatch_fire,    // Dispatch accepted this cycle
	output logic      dispatch_ready,   // Dispatch would be accepted
	output logic      retire_valid,     // Head row leaves this cycle
	output phys_tag_t retire_t_arch,    // New tag becomes architectural
	output phys_tag_t retire_t_free,    // Old tag returns to the free list
	output logic      retire_halt,
	output logic      rob_full,
	output rob_idx_t  rob_free_entries
);

	rob_row_t [ROB_SIZE-1:0] table_q;  // Row storage
	rob_row_t [ROB_SIZE-1:0] table_d;
	rob_idx_t                head_q;   // Oldest instruction
	rob_idx_t                tail_q;   // Next free row
	rob_idx_t                head_d;
	rob_idx_t                tail_d;
	rob_idx_t                tail_inc; // Tail plus one with wrap
	rob_idx_t                occupancy;
	logic [ROB_SIZE-1:0]     cam_hit;  // Rows completed by this broadcast

	rob_tag_cam u_cam (
		.rob_table (table_q),
		.cdb_valid (cdb_valid),
		.cdb_tag   (cdb_tag),
		.hit       (cam_hit)
	);

	// Status from registered pointers only
	assign tail_inc         = tail_q + rob_idx_t'(1);
	assign rob_full         = (tail_inc == head_q);
	assign occupancy        = tail_q - head_q;  // Modulo ROB_SIZE
	assign rob_free_entries = rob_idx_t'(ROB_SIZE - 1) - occupancy;

	// Acceptance needs a free row and a free tag
	assign dispatch_ready = !rob_full && !free_empty;
	assign dispatch_fire  = dispatch_en && dispatch_ready;

	// Head retires once its result has been broadcast
	assign retire_valid  = table_q[head_q].busy && table_q[head_q].ready;
	assign retire_t_arch = table_q[head_q].t_new;
	assign retire_t_free = table_q[head_q].t_old;
	assign retire_halt   = retire_valid && table_q[head_q].halt;

	always_comb begin
		table_d = table_q;
		head_d  = head_q;
		tail_d  = tail_q;

		// Completion marks stay sticky until the row is freed
		for (int i = 0; i < ROB_SIZE; i++) begin
			table_d[i].ready = table_q[i].ready | cam_hit[i];
		end

		// Retire clears the head row
		if (retire_valid) begin
			table_d[head_q] = '0;
			head_d          = head_q + rob_idx_t'(1);
		end

		// Tail row is never the head row of a non-empty buffer
		if (dispatch_fire) begin
			table_d[tail_q].busy  = 1'b1;
			table_d[tail_q].ready = 1'b0;
			table_d[tail_q].t_new = t_new;
			table_d[tail_q].t_old = t_old;
			table_d[tail_q].halt  = dispatch_halt;
			tail_d                = tail_inc;
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n || flush) begin
			table_q <= '0;   // Empty buffer
			head_q  <= '0;
			tail_q  <= '0;
		end else begin
			table_q <= table_d;
			head_q  <= head_d;
			tail_q  <= tail_d;
		end
	end

	// Tags in flight are unique only if free list and map never duplicate one
	a_cam_onehot: assert property (@(posedge clock) disable iff (!rst_n || flush)
		$onehot0(cam_hit))
		else $error("rob_core: CDB tag %h hit more than one row", cdb_tag);

	// Pointers and busy bits must agree, so an accepted dispatch lands on an idle row
	a_fire_idle_row: assert property (@(posedge clock) disable iff (!rst_n || flush)
		dispatch_fire |-> !table_q[tail_q].busy)
		else $error("rob_core: dispatch onto busy row %0d", tail_q);

	// A ready head row only exists while the pointers show work in flight
	a_retire_nonempty: assert property (@(posedge clock) disable iff (!rst_n || flush)
		retire_valid |-> (occupancy != '0))
		else $error("rob_core: retire from an empty buffer at head row %0d", head_q);

endmodule

/* rtl/free_list.sv */
`timescale 1ns/1ps

module free_list
	import reg_pkg::*;
(
	input  logic      clock,
	input  logic      rst_n,
	input  logic      flush,
	input  logic      pop,        // Tag taken at dispatch
	input  logic      push,       // Tag returned at retire
	input  phys_tag_t push_tag,
	output phys_tag_t head_tag,   // Next tag to hand out
	output logic      free_empty
);

	phys_tag_t                    entries [FREE_REGS]; // Circular tag store
	logic [$clog2(FREE_REGS)-1:0] head_ptr;            // Read side
	logic [$clog2(FREE_REGS)-1:0] tail_ptr;            // Write side
	logic [$clog2(FREE_REGS):0]   count;               // 0..FREE_REGS

	assign head_tag   = entries[head_ptr];
	assign free_empty = (count == '0);

	always_ff @(posedge clock) begin
		if (!rst_n || flush) begin
			// Full list of the tags above the identity map, ascending
			for (int i = 0; i < FREE_REGS; i++) begin
				entries[i] <= phys_tag_t'(ARCH_REGS + i);
			end
			head_ptr <= '0;
			tail_ptr <= '0;  // Full, so tail has wrapped onto head
			count    <= ($clog2(FREE_REGS) + 1)'(FREE_REGS);
		end else begin
			if (pop) begin
				head_ptr <= head_ptr + 1'b1;
			end
			if (push) begin
				entries[tail_ptr] <= push_tag;
				tail_ptr          <= tail_ptr + 1'b1;
			end
			// Simultaneous pop and push leave the count alone
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Tag conservation with the map and ROB keeps the list from overflowing
	a_no_overflow: assert property (@(posedge clock) disable iff (!rst_n || flush)
		push |-> (count != ($clog2(FREE_REGS) + 1)'(FREE_REGS)))
		else $error("free_list: push of tag %h into a full list", push_tag);

	a_no_underflow: assert property (@(posedge clock) disable iff (!rst_n || flush)
		pop |-> !free_empty)
		else $error("free_list: pop from an empty list");

endmodule

/* rtl/map_table.sv */
`timescale 1ns/1ps

module map_table
	import reg_pkg::*;
(
	input  logic      clock,
	input  logic      rst_n,
	input  logic      flush,
	input  logic      write_en, // Dispatch accepted
	input  arch_reg_t arch,     // Destination register
	input  phys_tag_t new_tag,  // Tag from the free list
	output phys_tag_t old_tag   // Current mapping of arch
);

	phys_tag_t map_q [ARCH_REGS];

	// Read before the write lands, so old_tag is the previous mapping
	assign old_tag = map_q[arch];

	always_ff @(posedge clock) begin
		if (!rst_n || flush) begin
			// Identity map, register i lives in tag i
			for (int i = 0; i < ARCH_REGS; i++) begin
				map_q[i] <= phys_tag_t'(i);
			end
		end else if (write_en) begin
			map_q[arch] <= new_tag;
		end
	end

endmodule

/* rtl/rename_rob_top.sv */
`timescale 1ns/1ps

module rename_rob_top
	import reg_pkg::*;
	import rob_pkg::*;
(
	input  logic      clock,
	input  logic      rst_n,
	input  logic      flush,
	input  logic      dispatch_en,
	input  arch_reg_t dispatch_arch,    // Destination of the dispatching instruction
	input  logic      dispatch_halt,
	input  logic      cdb_valid,
	input  phys_tag_t cdb_tag,
	output logic      dispatch_ready,
	output phys_tag_t dispatch_t_new,   // Free list head
	output phys_tag_t dispatch_t_old,   // Map table read
	output logic      retire_valid,
	output phys_tag_t retire_t_arch,
	output phys_tag_t retire_t_free,
	output logic      retire_halt,
	output logic      rob_full,
	output rob_idx_t  rob_free_entries
);

	logic dispatch_fire; // Single acceptance strobe shared by all three blocks
	logic free_empty;

	// Rename, old mapping out and new mapping in
	map_table u_map (
		.clock    (clock),
		.rst_n    (rst_n),
		.flush    (flush),
		.write_en (dispatch_fire),
		.arch     (dispatch_arch),
		.new_tag  (dispatch_t_new),
		.old_tag  (dispatch_t_old)
	);

	// Old tags recycle through the free list at retire
	free_list u_free (
		.clock      (clock),
		.rst_n      (rst_n),
		.flush      (flush),
		.pop        (dispatch_fire),
		.push       (retire_valid),
		.push_tag   (retire_t_free),
		.head_tag   (dispatch_t_new),
		.free_empty (free_empty)
	);

	rob_core u_rob (
		.clock            (clock),
		.rst_n            (rst_n),
		.flush            (flush),
		.dispatch_en      (dispatch_en),
		.dispatch_halt    (dispatch_halt),
		.t_new            (dispatch_t_new),
		.t_old            (dispatch_t_old),
		.free_empty       (free_empty),
		.cdb_valid        (cdb_valid),
		.cdb_tag          (cdb_tag),
		.dispatch_fire    (dispatch_fire),
		.dispatch_ready   (dispatch_ready),
		.retire_valid     (retire_valid),
		.retire_t_arch    (retire_t_arch),
		.retire_t_free    (retire_t_free),
		.retire_halt      (retire_halt),
		.rob_full         (rob_full),
		.rob_free_entries (rob_free_entries)
	);

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int HALF_PERIOD  = 2, // 4 ns period
	parameter int RESET_CYCLES = 3
) (
	output logic clock,
	output logic rst_n
);

	initial begin
		clock = 1'b0;
		forever #(HALF_PERIOD) clock = ~clock;
	end

	// Reset held over three rising edges, released on a falling edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
	end

endmodule

/* tb/tb_rename_rob.sv */
`timescale 1ns/1ps

module tb_rename_rob
	import reg_pkg::*;
	import rob_pkg::*;
();

	localparam int RANDOM_CYCLES   = 300;
	localparam int DIRECTED_CYCLES = 80;  // Directed steps and drains, upper estimate
	localparam int TIMEOUT_CYCLES  = 2 * (RANDOM_CYCLES + DIRECTED_CYCLES) + 100;

	// One in-flight instruction of the reference model
	typedef struct packed {
		phys_tag_t t_new;
		phys_tag_t t_old;
		logic      halt;
		logic      ready;
	} flight_t;

	logic      clock;
	logic      rst_n;
	logic      flush;
	logic      dispatch_en;
	arch_reg_t dispatch_arch;
	logic      dispatch_halt;
	logic      cdb_valid;
	phys_tag_t cdb_tag;
	logic      dispatch_ready;
	phys_tag_t dispatch_t_new;
	phys_tag_t dispatch_t_old;
	logic      retire_valid;
	phys_tag_t retire_t_arch;
	phys_tag_t retire_t_free;
	logic      retire_halt;
	logic      rob_full;
	rob_idx_t  rob_free_entries;

	// Reference model state
	phys_tag_t model_map [ARCH_REGS];
	phys_tag_t free_q [$];   // Free tags in hand-out order
	flight_t   inflight [$]; // Oldest first

	// Expected port values, refreshed after every model step and every drive
	logic      exp_ready;
	logic      exp_full;
	rob_idx_t  exp_free_entries;
	phys_tag_t exp_t_new;
	phys_tag_t exp_t_old;
	logic      exp_retire_valid;
	phys_tag_t exp_retire_arch;
	phys_tag_t exp_retire_free;
	logic      exp_retire_halt;

	integer seed = 38938;
	int     error_count    = 0;
	int     cycle_count    = 0;
	int     full_stalls    = 0; // Dispatches refused by back-pressure
	int     halt_retires   = 0;
	int     dispatch_total = 0;

	tb_clock_gen clock_gen0 (
		.clock (clock),
		.rst_n (rst_n)
	);

	rename_rob_top dut0 (
		.clock            (clock),
		.rst_n            (rst_n),
		.flush            (flush),
		.dispatch_en      (dispatch_en),
		.dispatch_arch    (dispatch_arch),
		.dispatch_halt    (dispatch_halt),
		.cdb_valid        (cdb_valid),
		.cdb_tag          (cdb_tag),
		.dispatch_ready   (dispatch_ready),
		.dispatch_t_new   (dispatch_t_new),
		.dispatch_t_old   (dispatch_t_old),
		.retire_valid     (retire_valid),
		.retire_t_arch    (retire_t_arch),
		.retire_t_free    (retire_t_free),
		.retire_halt      (retire_halt),
		.rob_full         (rob_full),
		.rob_free_entries (rob_free_entries)
	);

	task automatic report_mismatch(input string name, input logic [7:0] expected,
			input logic [7:0] actual);
		error_count++;
		$display("FAILED %s expected %h got %h at %0t", name, expected, actual, $time);
	endtask

	// Identity map, tags 32..63 free, nothing in flight
	task automatic reset_model();
		for (int i = 0; i < ARCH_REGS; i++) begin
			model_map[i] = phys_tag_t'(i);
		end
		free_q.delete();
		for (int i = 0; i < FREE_REGS; i++) begin
			free_q.push_back(phys_tag_t'(ARCH_REGS + i));
		end
		inflight.delete();
	endtask

	task automatic compute_expect();
		exp_ready        = (inflight.size() < ROB_SIZE - 1) && (free_q.size() > 0);
		exp_full         = (inflight.size() == ROB_SIZE - 1);
		exp_free_entries = rob_idx_t'(ROB_SIZE - 1 - inflight.size());
		exp_t_new        = (free_q.size() > 0) ? free_q[0] : '0;
		exp_t_old        = model_map[dispatch_arch]; // Mapping before this dispatch
		exp_retire_valid = (inflight.size() > 0) && inflight[0].ready;
		exp_retire_arch  = (inflight.size() > 0) ? inflight[0].t_new : '0;
		exp_retire_free  = (inflight.size() > 0) ? inflight[0].t_old : '0;
		exp_retire_halt  = exp_retire_valid && inflight[0].halt;
	endtask

	// Model step, in the same order the hardware sees the pre-edge state
	always @(posedge clock) begin : model_update
		flight_t head;
		flight_t entry;
		if (!rst_n || flush) begin
			reset_model();
		end else begin
			// Retire uses ready bits from before this edge
			if (inflight.size() > 0 && inflight[0].ready) begin
				head = inflight.pop_front();
				free_q.push_back(head.t_old);
				if (head.halt) halt_retires++;
			end
			if (cdb_valid) begin
				foreach (inflight[i]) begin
					if (inflight[i].t_new == cdb_tag) inflight[i].ready = 1'b1;
				end
			end
			if (dispatch_en && exp_ready) begin
				entry.t_new = free_q.pop_front();
				entry.t_old = model_map[dispatch_arch];
				entry.halt  = dispatch_halt;
				entry.ready = 1'b0;
				model_map[dispatch_arch] = entry.t_new;
				inflight.push_back(entry);
				dispatch_total++;
			end else if (dispatch_en) begin
				full_stalls++; // Dropped, nothing changes
			end
		end
		compute_expect();
	end

	// Port checks against the model
	a_ready: assert property (@(posedge clock) disable iff (!rst_n)
		dispatch_ready == exp_ready)
		else report_mismatch("dispatch_ready", 8'($sampled(exp_ready)),
			8'($sampled(dispatch_ready)));

	a_full: assert property (@(posedge clock) disable iff (!rst_n)
		rob_full == exp_full)
		else report_mismatch("rob_full", 8'($sampled(exp_full)), 8'($sampled(rob_full)));

	a_free_entries: assert property (@(posedge clock) disable iff (!rst_n)
		rob_free_entries == exp_free_entries)
		else report_mismatch("rob_free_entries", 8'($sampled(exp_free_entries)),
			8'($sampled(rob_free_entries)));

	a_t_new: assert property (@(posedge clock) disable iff (!rst_n)
		dispatch_t_new == exp_t_new)
		else report_mismatch("dispatch_t_new", 8'($sampled(exp_t_new)),
			8'($sampled(dispatch_t_new)));

	a_t_old: assert property (@(posedge clock) disable iff (!rst_n)
		dispatch_t_old == exp_t_old)
		else report_mismatch("dispatch_t_old", 8'($sampled(exp_t_old)),
			8'($sampled(dispatch_t_old)));

	// No retire before the tag has been broadcast
	a_retire_valid: assert property (@(posedge clock) disable iff (!rst_n)
		retire_valid == exp_retire_valid)
		else report_mismatch("retire_valid", 8'($sampled(exp_retire_valid)),
			8'($sampled(retire_valid)));

	a_retire_arch: assert property (@(posedge clock) disable iff (!rst_n)
		exp_retire_valid |-> retire_t_arch == exp_retire_arch)
		else report_mismatch("retire_t_arch", 8'($sampled(exp_retire_arch)),
			8'($sampled(retire_t_arch)));

	a_retire_free: assert property (@(posedge clock) disable iff (!rst_n)
		exp_retire_valid |-> retire_t_free == exp_retire_free)
		else report_mismatch("retire_t_free", 8'($sampled(exp_retire_free)),
			8'($sampled(retire_t_free)));

	a_retire_halt: assert property (@(posedge clock) disable iff (!rst_n)
		retire_halt == exp_retire_halt)
		else report_mismatch("retire_halt", 8'($sampled(exp_retire_halt)),
			8'($sampled(retire_halt)));

	// Called on a falling edge, returns on the next one
	task automatic drive_cycle(input logic en, input arch_reg_t arch, input logic halt,
			input logic cv, input phys_tag_t tag, input logic fl);
		dispatch_en   = en;
		dispatch_arch = arch;
		dispatch_halt = halt;
		cdb_valid     = cv;
		cdb_tag       = tag;
		flush         = fl;
		compute_expect(); // t_old follows the new dispatch_arch
		@(negedge clock);
	endtask

	task automatic dispatch_reg(input arch_reg_t arch, input logic halt);
		drive_cycle(1'b1, arch, halt, 1'b0, '0, 1'b0);
	endtask

	task automatic idle_cycle();
		drive_cycle(1'b0, '0, 1'b0, 1'b0, '0, 1'b0);
	endtask

	// Random busy row that has not completed yet
	task automatic pick_pending_tag(output logic found, output phys_tag_t tag);
		int pending;
		int pick;
		pending = 0;
		found   = 1'b0;
		tag     = '0;
		foreach (inflight[i]) begin
			if (!inflight[i].ready) pending++;
		end
		if (pending > 0) begin
			pick = $unsigned($random(seed)) % pending;
			foreach (inflight[i]) begin
				if (!inflight[i].ready) begin
					if (pick == 0 && !found) begin
						found = 1'b1;
						tag   = inflight[i].t_new;
					end
					pick--;
				end
			end
		end
	endtask

	task automatic random_cycle();
		logic      en;
		logic      halt;
		logic      found;
		arch_reg_t arch;
		phys_tag_t tag;
		en   = ($unsigned($random(seed)) % 4) != 0; // Dispatch about three cycles in four
		arch = arch_reg_t'($random(seed));
		halt = ($unsigned($random(seed)) % 8) == 0;
		pick_pending_tag(found, tag);
		if (found) found = ($unsigned($random(seed)) % 3) != 0;
		drive_cycle(en, arch, halt, found, tag, 1'b0);
	endtask

	// Complete everything in flight and wait until the DUT reports empty
	task automatic drain();
		logic      found;
		phys_tag_t tag;
		while (rob_free_entries != rob_idx_t'(ROB_SIZE - 1)) begin
			pick_pending_tag(found, tag);
			drive_cycle(1'b0, '0, 1'b0, found, tag, 1'b0);
		end
	endtask

	// Cycle limit
	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the run did not finish", cycle_count);
			$display("errors: %0d", error_count + 1);
			$display("tests failed");
			$finish;
		end
	end

	initial begin
		flush         = 1'b0;
		dispatch_en   = 1'b0;
		dispatch_arch = '0;
		dispatch_halt = 1'b0;
		cdb_valid     = 1'b0;
		cdb_tag       = '0;
		reset_model();
		compute_expect();
		@(posedge rst_n); // Released on a falling edge

		// Reset state, then first renames
		idle_cycle();
		dispatch_reg(5'd0, 1'b0);
		dispatch_reg(5'd1, 1'b0);
		dispatch_reg(5'd2, 1'b0);
		dispatch_reg(5'd1, 1'b0); // Repeated destination
		// Fill to seven with no completions
		dispatch_reg(5'd3, 1'b0);
		dispatch_reg(5'd4, 1'b0);
		dispatch_reg(5'd1, 1'b0);
		repeat (3) dispatch_reg(5'd9, 1'b0); // Refused while full
		drive_cycle(1'b1, 5'd9, 1'b0, 1'b1, inflight[0].t_new, 1'b0); // Complete head
		dispatch_reg(5'd9, 1'b0);
		dispatch_reg(5'd9, 1'b0);
		drain();

		// Random completion order, tags recycle after the first 32
		repeat (RANDOM_CYCLES) random_cycle();
		drain();

		// Halt entry
		dispatch_reg(5'd7, 1'b1);
		dispatch_reg(5'd8, 1'b0);
		drain();

		// Flush with work in flight
		dispatch_reg(5'd10, 1'b0);
		dispatch_reg(5'd11, 1'b1);
		drive_cycle(1'b1, 5'd12, 1'b0, 1'b1, inflight[0].t_new, 1'b0);
		drive_cycle(1'b0, '0, 1'b0, 1'b0, '0, 1'b1);
		idle_cycle();
		dispatch_reg(5'd0, 1'b0);
		dispatch_reg(5'd1, 1'b0);
		dispatch_reg(5'd2, 1'b0);
		drain();
		idle_cycle();

		if (full_stalls == 0) begin
			error_count++;
			$display("No dispatch was ever refused by a full buffer");
		end
		if (halt_retires == 0) begin
			error_count++;
			$display("No halt-flagged entry ever retired");
		end
		if (dispatch_total <= FREE_REGS) begin
			error_count++;
			$display("Too few dispatches to reuse any freed tag");
		end

		$display("errors: %0d, dispatches: %0d, stalls: %0d, halt retires: %0d",
			error_count, dispatch_total, full_stalls, halt_retires);
		if (error_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* tb.f */
rtl/reg_pkg.sv
rtl/rob_pkg.sv
rtl/rob_tag_cam.sv
rtl/rob_core.sv
rtl/free_list.sv
rtl/map_table.sv
rtl/rename_rob_top.sv
tb/tb_clock_gen.sv
tb/tb_rename_rob.sv

/* Bender.yml */
package:
  name: rename_rob

sources:
  - rtl/reg_pkg.sv
  - rtl/rob_pkg.sv
  - rtl/rob_tag_cam.sv
  - rtl/rob_core.sv
  - rtl/free_list.sv
  - rtl/map_table.sv
  - rtl/rename_rob_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_rename_rob.sv
